// ==== hdl/dcachePkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and geometry for the two-way data cache.
// Byte addresses are 32 bits. Every block holds two words.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dcachePkg;

	// One data word or byte address
	typedef logic [31:0] wordT;

	// Controller states
	typedef enum logic [3:0] {
		idle      = 4'h0,
		readHit   = 4'h1,
		overwrite = 4'h2,
		writeHit  = 4'h3,
		// Write-back of the victim, word 0 then word 1
		cleanA    = 4'h4,
		cleanB    = 4'h5,
		// Refill of the requested block, word 0 then word 1
		fillA     = 4'h6,
		fillB     = 4'h7,
		flushScan = 4'h8,
		stopped   = 4'h9
	} ctrlStateT;

	// Bytes within a word are not addressed by the cache
	localparam int byteOffBits = 2;

	// Words per block
	localparam int blockWords = 2;

endpackage

// ==== hdl/cacheIf.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lookup results one way, update pulses the other way.
// Pulses act at the clock edge that ends the cycle they are high.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface cacheIf import dcachePkg::*; #(
	parameter int setBits = 3
) ();

	// Index field would be empty otherwise
	if (setBits < 1) begin : setCheck
		$error("cacheIf needs at least two sets");
	end

	// Frame store side
	logic lookupHit;
	wordT loadWord;
	logic victimDirty;
	wordT victimAddr;
	wordT victimData;
	logic anyDirty;

	// Controller side
	logic flushMode;
	logic wordSel;
	logic fillWord;
	logic fillDone;
	logic storeWord;
	logic cleanVictim;
	logic touch;

	modport store (
		output lookupHit, loadWord, victimDirty, victimAddr, victimData, anyDirty,
		input  flushMode, wordSel, fillWord, fillDone, storeWord, cleanVictim, touch
	);

	modport control (
		input  lookupHit, loadWord, victimDirty, victimAddr, victimData, anyDirty,
		output flushMode, wordSel, fillWord, fillDone, storeWord, cleanVictim, touch
	);

endinterface

// ==== hdl/frameStore.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two ways of frames plus one LRU bit per set.
// Tags and data words are not cleared by reset, only valid,
// dirty and LRU state.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module frameStore import dcachePkg::*; #(
	parameter int setBits = 3
) (
	input  logic CLK,
	input  logic nRST,
	input  wordT memAddr,
	input  wordT memStore,
	input  wordT ramLoad,
	input  logic memRead,
	input  logic memWrite,
	cacheIf.store cif
);

	// Address fields, low to high: byte offset, word bit, index, tag
	localparam int wordBit = byteOffBits;
	localparam int idxLo   = byteOffBits + $clog2(blockWords);
	localparam int tagLo   = idxLo + setBits;
	localparam int tagBits = 32 - tagLo;
	localparam int sets    = 1 << setBits;

	typedef logic [tagBits-1:0] tagT;
	typedef logic [setBits-1:0] idxT;

	// Frame contents
	tagT  tags [2][sets];
	wordT data [2][sets][blockWords];
	logic [1:0][sets-1:0] valid;
	logic [1:0][sets-1:0] dirty;

	// Most recently used way of each set
	logic [sets-1:0] lru;

	idxT  reqIdx;
	tagT  reqTag;
	logic reqWord;

	logic [1:0] wayHit;
	logic hitWay;

	logic flushWay;
	idxT  flushIdx;
	logic replWay;

	logic vWay;
	idxT  vIdx;

	assign reqIdx  = memAddr[idxLo +: setBits];
	assign reqTag  = memAddr[tagLo +: tagBits];
	assign reqWord = memAddr[wordBit];

	// Tag compare on both ways of the indexed set
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			wayHit[w] = valid[w][reqIdx] && (tags[w][reqIdx] == reqTag);
		end
	end

	// Way 0 wins if both ever matched
	assign hitWay = ~wayHit[0];

	assign cif.lookupHit = (memRead || memWrite) && (|wayHit);
	assign cif.loadWord  = data[hitWay][reqIdx][reqWord];

	// First dirty frame, way 0 by index, then way 1
	// Scanned backwards so the earliest match is assigned last
	always_comb begin
		flushWay = 1'b0;
		flushIdx = '0;
		for (int w = 1; w >= 0; w--) begin
			for (int i = sets - 1; i >= 0; i--) begin
				if (dirty[w][i]) begin
					flushWay = 1'(w);
					flushIdx = idxT'(i);
				end
			end
		end
	end

	assign cif.anyDirty = |dirty;

	// Replacement choice: invalid way first, else the older one
	always_comb begin
		if (!valid[0][reqIdx]) begin
			replWay = 1'b0;
		end else if (!valid[1][reqIdx]) begin
			replWay = 1'b1;
		end else begin
			replWay = ~lru[reqIdx];
		end
	end

	assign vWay = cif.flushMode ? flushWay : replWay;
	assign vIdx = cif.flushMode ? flushIdx : reqIdx;

	assign cif.victimDirty = dirty[vWay][vIdx];
	assign cif.victimAddr  = {tags[vWay][vIdx], vIdx, {idxLo{1'b0}}};
	assign cif.victimData  = data[vWay][vIdx][cif.wordSel];

	// Frame status bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
			lru   <= '0;
		end else begin
			if (cif.fillDone) begin
				valid[vWay][vIdx] <= 1'b1;
				dirty[vWay][vIdx] <= 1'b0;
			end
			if (cif.cleanVictim) begin
				dirty[vWay][vIdx] <= 1'b0;
			end
			// Store always lands on a resident block
			if (cif.storeWord) begin
				dirty[hitWay][reqIdx] <= 1'b1;
			end
			if (cif.touch) begin
				lru[reqIdx] <= hitWay;
			end
		end
	end

	// Tags and words
	always_ff @(posedge CLK) begin
		if (cif.fillWord) begin
			data[vWay][vIdx][cif.wordSel] <= ramLoad;
		end
		if (cif.fillDone) begin
			tags[vWay][vIdx] <= reqTag;
		end
		if (cif.storeWord) begin
			data[hitWay][reqIdx][reqWord] <= memStore;
		end
	end

endmodule

// ==== hdl/cacheController.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Miss, write-back and flush sequencing for the data cache.
// One request at a time; ramWait stalls every memory state.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cacheController import dcachePkg::*; #(
	parameter int setBits = 3
) (
	input  logic CLK,
	input  logic nRST,
	input  logic memRead,
	input  logic memWrite,
	input  logic halt,
	input  wordT memAddr,
	input  logic ramWait,
	output logic hit,
	output logic flushed,
	output wordT memLoad,
	output logic ramRead,
	output logic ramWrite,
	output wordT ramAddr,
	output wordT ramStore,
	cacheIf.control cif
);

	localparam int tagBits = 32 - byteOffBits - $clog2(blockWords) - setBits;

	// Too many sets would leave no tag
	if (tagBits < 1) begin : tagCheck
		$error("setBits leaves no room for a tag");
	end

	// Low address bits that select a word inside the block
	localparam wordT blockMask = wordT'((blockWords << byteOffBits) - 1);

	ctrlStateT state;
	ctrlStateT nextState;

	// Set on entry to the flush scan, held until reset
	logic flushActive;

	wordT reqBlock;
	wordT wordOff;

	assign reqBlock = memAddr & ~blockMask;

	// Second word in cleanB and fillB
	assign cif.wordSel = (state == cleanB) || (state == fillB);
	assign wordOff     = wordT'(cif.wordSel) << byteOffBits;

	assign cif.flushMode = flushActive;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state       <= idle;
			flushActive <= 1'b0;
		end else begin
			state <= nextState;
			if (nextState == flushScan) begin
				flushActive <= 1'b1;
			end
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				if (halt) begin
					nextState = flushScan;
				end else if (cif.lookupHit) begin
					nextState = memWrite ? overwrite : readHit;
				end else if (memRead || memWrite) begin
					nextState = cif.victimDirty ? cleanA : fillA;
				end
			end
			readHit:   nextState = idle;
			overwrite: nextState = writeHit;
			writeHit:  nextState = idle;
			cleanA: begin
				if (!ramWait) begin
					nextState = cleanB;
				end
			end
			cleanB: begin
				if (!ramWait) begin
					nextState = halt ? flushScan : fillA;
				end
			end
			fillA: begin
				if (!ramWait) begin
					nextState = fillB;
				end
			end
			fillB: begin
				// A write miss stores its word once the block is in
				if (!ramWait) begin
					nextState = memWrite ? overwrite : idle;
				end
			end
			flushScan: nextState = cif.anyDirty ? cleanA : stopped;
			stopped:   nextState = stopped;
			default:   nextState = idle;
		endcase
	end

	always_comb begin
		hit             = 1'b0;
		memLoad         = '0;
		flushed         = 1'b0;
		ramRead         = 1'b0;
		ramWrite        = 1'b0;
		ramAddr         = '0;
		ramStore        = '0;
		cif.fillWord    = 1'b0;
		cif.fillDone    = 1'b0;
		cif.storeWord   = 1'b0;
		cif.cleanVictim = 1'b0;
		cif.touch       = 1'b0;
		case (state)
			readHit: begin
				hit       = 1'b1;
				memLoad   = cif.loadWord;
				cif.touch = 1'b1;
			end
			overwrite: begin
				cif.storeWord = 1'b1;
			end
			writeHit: begin
				hit       = 1'b1;
				cif.touch = 1'b1;
			end
			cleanA, cleanB: begin
				ramWrite = 1'b1;
				ramAddr  = cif.victimAddr + wordOff;
				ramStore = cif.victimData;
				// Frame is clean only after its last word is out
				cif.cleanVictim = (state == cleanB) && !ramWait;
			end
			fillA, fillB: begin
				ramRead      = 1'b1;
				ramAddr      = reqBlock + wordOff;
				cif.fillWord = !ramWait;
				cif.fillDone = (state == fillB) && !ramWait;
			end
			stopped: begin
				flushed = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== hdl/dcacheTop.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-way write-back data cache, two words per block.
// Processor holds a request until hit; flushed stays until reset.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dcacheTop import dcachePkg::*; #(
	parameter int setBits = 3
) (
	input  logic CLK,
	input  logic nRST,

	// Processor side
	input  logic memRead,
	input  logic memWrite,
	input  wordT memAddr,
	input  wordT memStore,
	input  logic halt,
	output logic hit,
	output wordT memLoad,
	output logic flushed,

	// Memory side
	output logic ramRead,
	output logic ramWrite,
	output wordT ramAddr,
	output wordT ramStore,
	input  wordT ramLoad,
	input  logic ramWait
);

	cacheIf #(.setBits(setBits)) cif ();

	frameStore #(.setBits(setBits)) frameStore_i (
		.CLK      (CLK),
		.nRST     (nRST),
		.memAddr  (memAddr),
		.memStore (memStore),
		.ramLoad  (ramLoad),
		.memRead  (memRead),
		.memWrite (memWrite),
		.cif      (cif.store)
	);

	cacheController #(.setBits(setBits)) cacheController_i (
		.CLK      (CLK),
		.nRST     (nRST),
		.memRead  (memRead),
		.memWrite (memWrite),
		.halt     (halt),
		.memAddr  (memAddr),
		.ramWait  (ramWait),
		.hit      (hit),
		.flushed  (flushed),
		.memLoad  (memLoad),
		.ramRead  (ramRead),
		.ramWrite (ramWrite),
		.ramAddr  (ramAddr),
		.ramStore (ramStore),
		.cif      (cif.control)
	);

endmodule

// ==== test/dcacheAsserts.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol rules on the cache's ports, bound into dcacheTop.
// Checks are off while nRST is low.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dcacheAsserts import dcachePkg::*; (
	input logic CLK,
	input logic nRST,
	input logic hit,
	input logic flushed,
	input logic ramRead,
	input logic ramWrite,
	input wordT ramAddr
);

	int failCount = 0;

	noOverlap: assert property (@(posedge CLK) disable iff (!nRST) !(ramRead && ramWrite))
	else begin
		failCount++;
		$error("ramRead and ramWrite high in the same cycle");
	end

	// Hit is a single-cycle pulse
	hitPulse: assert property (@(posedge CLK) disable iff (!nRST) hit |=> !hit)
	else begin
		failCount++;
		$error("hit stayed high for more than one cycle");
	end

	flushHeld: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
	else begin
		failCount++;
		$error("flushed fell before reset");
	end

	wordAligned: assert property (@(posedge CLK) disable iff (!nRST) ramAddr[1:0] == 2'b00)
	else begin
		failCount++;
		$error("ramAddr is not word aligned");
	end

endmodule

bind dcacheTop dcacheAsserts dcacheAsserts_i (.*);

// ==== test/dcacheTb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random reads and writes over three tags and four sets, then a flush.
// Memory model holds 256 words and stalls each word 0 to 3 cycles.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dcacheTb import dcachePkg::*; ();

	localparam int setBits = 3;
	localparam int sets = 1 << setBits;
	localparam int clkPeriod = 40;
	localparam int numOps = 400;
	// Two write-backs and two fills at four cycles each, plus request overhead
	localparam int opCycles = 30;
	localparam int watchdogCycles = numOps * opCycles + 2 * sets * 10 + 20;

	logic CLK = 1'b0;
	logic nRST;
	logic memRead;
	logic memWrite;
	wordT memAddr;
	wordT memStore;
	logic halt;
	logic hit;
	wordT memLoad;
	logic flushed;
	logic ramRead;
	logic ramWrite;
	wordT ramAddr;
	wordT ramStore;
	wordT ramLoad;
	logic ramWait = 1'b0;

	// Memory model and its log of completed transfers
	wordT ramMem [256];
	int   waitLeft = 0;
	logic xferWrite [$];
	wordT xferAddr [$];
	wordT xferData [$];
	int   xferPos = 0;

	// Reference image and per-set cache model
	wordT refMem [256];
	logic mValid [2][sets] = '{default: 1'b0};
	logic mDirty [2][sets] = '{default: 1'b0};
	wordT mBlock [2][sets];
	logic mMru [sets] = '{default: 1'b0};

	always #(clkPeriod / 2) CLK = ~CLK;

	// Combinational read port of the memory model
	assign ramLoad = ramMem[ramAddr[9:2]];

	dcacheTop #(.setBits(setBits)) dcacheTop_i (.*);

	function automatic wordT randomAddr();
		int tag;
		case ($urandom % 3)
			0: tag = 1;
			1: tag = 6;
			default: tag = 13;
		endcase
		return wordT'((tag << (setBits + 3)) + (($urandom % 4) << 3) + (($urandom % 2) << 2));
	endfunction

	task automatic abortRun();
		$display("TB FAILED");
		$fatal(1, "Run stopped at %0t", $time);
	endtask

	task automatic checkWord(string what, wordT got, wordT exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
			abortRun();
		end
	endtask

	task automatic checkEvent(string what, logic got, logic exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
			abortRun();
		end
	endtask

	// Next logged transfer must match kind, address and image data
	task automatic expectXfer(logic isWrite, wordT addr);
		checkEvent("transfer is a write", xferWrite[xferPos], isWrite);
		checkWord("transfer address", xferAddr[xferPos], addr);
		checkWord("transfer data", xferData[xferPos], refMem[addr[9:2]]);
		xferPos++;
	endtask

	task automatic runAccess(logic isWrite, wordT addr, wordT data);
		int   idx;
		int   cycles;
		wordT blk;
		logic isHit;
		logic way;
		logic evictDirty;
		wordT evictBlk;
		idx = int'(addr[byteOffBits + 1 +: setBits]);
		blk = addr & ~wordT'(7);
		isHit = 1'b1;
		if (mValid[0][idx] && mBlock[0][idx] == blk) begin
			way = 1'b0;
		end else if (mValid[1][idx] && mBlock[1][idx] == blk) begin
			way = 1'b1;
		end else begin
			isHit = 1'b0;
			// Invalid way first, then the least recently used
			way = !mValid[0][idx] ? 1'b0 : (!mValid[1][idx] ? 1'b1 : ~mMru[idx]);
		end
		evictDirty = !isHit && mValid[way][idx] && mDirty[way][idx];
		evictBlk = mBlock[way][idx];
		@(posedge CLK);
		#1;
		memRead = !isWrite;
		memWrite = isWrite;
		memAddr = addr;
		memStore = data;
		// Request not sampled yet
		@(negedge CLK);
		checkEvent("hit before request sampled", hit, 1'b0);
		cycles = 0;
		do begin
			@(negedge CLK);
			cycles++;
			if (isHit) begin
				checkEvent("hit on resident block", hit, cycles == (isWrite ? 2 : 1));
			end
		end while (!hit);
		if (xferAddr.size() - xferPos != (evictDirty ? 2 : 0) + (isHit ? 0 : 2)) begin
			$display("Access to %h at %0t made the wrong number of memory transfers", addr, $time);
			abortRun();
		end
		if (evictDirty) begin
			expectXfer(1'b1, evictBlk);
			expectXfer(1'b1, evictBlk + 32'd4);
		end
		if (!isHit) begin
			expectXfer(1'b0, blk);
			expectXfer(1'b0, blk + 32'd4);
			mBlock[way][idx] = blk;
			mValid[way][idx] = 1'b1;
			mDirty[way][idx] = 1'b0;
		end
		if (!isWrite) begin
			checkWord("memLoad", memLoad, refMem[addr[9:2]]);
		end else begin
			mDirty[way][idx] = 1'b1;
			refMem[addr[9:2]] = data;
		end
		mMru[idx] = way;
		@(posedge CLK);
		#1;
		memRead = 1'b0;
		memWrite = 1'b0;
	endtask

	task automatic runFlush();
		int   wIdx;
		wordT flushBlk [$];
		logic written [256] = '{default: 1'b0};
		// Dirty frames in flush order, way 0 by index, then way 1
		for (int w = 0; w < 2; w++) begin
			for (int s = 0; s < sets; s++) begin
				if (mDirty[w][s]) begin
					flushBlk.push_back(mBlock[w][s]);
				end
			end
		end
		@(posedge CLK);
		#1;
		halt = 1'b1;
		do begin
			@(negedge CLK);
		end while (!flushed);
		if (xferAddr.size() - xferPos != 2 * flushBlk.size()) begin
			$display("Flush made the wrong number of memory transfers for %0d dirty frames",
				flushBlk.size());
			abortRun();
		end
		for (int b = 0; b < flushBlk.size(); b++) begin
			for (int k = 0; k < blockWords; k++) begin
				wIdx = int'(xferAddr[xferPos][9:2]);
				if (written[wIdx]) begin
					$display("Flush wrote address %h twice", xferAddr[xferPos]);
					abortRun();
				end
				written[wIdx] = 1'b1;
				expectXfer(1'b1, flushBlk[b] + wordT'(4 * k));
			end
		end
		for (int i = 0; i < 256; i++) begin
			checkWord($sformatf("memory word %0d after flush", i), ramMem[i], refMem[i]);
		end
	endtask

	// Memory model, a fresh wait count for every word
	initial begin
		for (int i = 0; i < 256; i++) begin
			ramMem[i] = {8'hc3, 8'(i), ~8'(i), 8'(i * 37)};
		end
		forever begin
			@(posedge CLK);
			#1;
			ramWait = (waitLeft > 0);
			@(negedge CLK);
			if ((ramRead || ramWrite) && ramWait) begin
				waitLeft--;
			end else begin
				if (ramRead || ramWrite) begin
					if (ramWrite) begin
						ramMem[ramAddr[9:2]] = ramStore;
					end
					xferWrite.push_back(ramWrite);
					xferAddr.push_back(ramAddr);
					xferData.push_back(ramWrite ? ramStore : ramLoad);
				end
				waitLeft = int'($urandom % 4);
			end
		end
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Timeout after %0d cycles, the cache stopped responding", watchdogCycles);
		abortRun();
	end

	// A failed protocol assertion ends the run at once
	initial begin
		wait (dcacheTop_i.dcacheAsserts_i.failCount != 0);
		$display("A protocol assertion failed at %0t", $time);
		abortRun();
	end

	initial begin
		logic isWrite;
		wordT addr;
		void'($urandom(32'h9b1c_0aa8));
		nRST = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memAddr = '0;
		memStore = '0;
		halt = 1'b0;
		for (int i = 0; i < 256; i++) begin
			refMem[i] = {8'hc3, 8'(i), ~8'(i), 8'(i * 37)};
		end
		repeat (2) @(posedge CLK);
		#1;
		nRST = 1'b1;
		for (int n = 0; n < numOps; n++) begin
			isWrite = ($urandom % 5) < 2;
			addr = randomAddr();
			runAccess(isWrite, addr, $urandom);
		end
		runFlush();
		if (dcacheTop_i.dcacheAsserts_i.failCount == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("%0d protocol assertions failed", dcacheTop_i.dcacheAsserts_i.failCount);
			abortRun();
		end
	end

endmodule

// ==== sources.f ====
hdl/dcachePkg.sv
hdl/cacheIf.sv
hdl/frameStore.sv
hdl/cacheController.sv
hdl/dcacheTop.sv
test/dcacheAsserts.sv
test/dcacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the cache testbench with Verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module dcacheTb -Mdir obj_dir -o dcacheSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Let assertion errors be counted by the testbench instead of stopping at the first one
./obj_dir/dcacheSim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1
